//--- ex_stage.f
+incdir+common
common/ex_pkg.sv
common/fu_issue_if.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/flu_writeback.sv
mult/mult.sv
hdl/ex_stage.sv
testbench/ex_stage_asserts.sv
testbench/tb_ex_stage.sv

//--- testbench/tb_ex_stage.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module tb_ex_stage;

    localparam int UNIT_ALU    = 0;
    localparam int UNIT_BRANCH = 1;
    localparam int UNIT_MULT   = 2;

    typedef logic [`EX_XLEN-1:0]          word_t;
    typedef logic [`EX_TRANS_ID_BITS-1:0] tid_t;

    // One row of stimulus and its expected response
    typedef struct {
        int             unit;
        ex_pkg::fu_op_e op;
        word_t          a;
        word_t          b;
        word_t          imm;
        word_t          pc;
        logic           compressed;
        logic           pred_taken;
        word_t          pred_target;
        tid_t           tid;
        word_t          exp_result;
        logic           exp_taken;
        word_t          exp_target;
        logic           exp_mispredict;
    } test_entry_t;

    // DUT inputs
    logic           clk_i;
    logic           rst_ni;
    logic           flush_i;
    logic           alu_valid_i;
    logic           branch_valid_i;
    logic           mult_valid_i;
    ex_pkg::fu_op_e operation_i;
    word_t          operand_a_i;
    word_t          operand_b_i;
    word_t          imm_i;
    word_t          pc_i;
    tid_t           trans_id_i;
    logic           is_compressed_i;
    logic           predict_taken_i;
    word_t          predict_target_i;
    // DUT outputs
    logic           flu_ready_o;
    logic           flu_valid_o;
    word_t          flu_result_o;
    tid_t           flu_trans_id_o;
    logic           resolve_branch_o;
    word_t          resolved_pc_o;
    word_t          resolved_target_o;
    logic           resolved_taken_o;
    logic           mispredict_o;

    test_entry_t    tests[$];
    ex_pkg::fu_op_e cur_op;
    integer         seed;
    int             error_count;
    int             failed_tests;
    int             test_count;
    int             errors_before;
    int             cycle_count;
    int             timeout_limit;
    int             idx;

    ex_stage ex_stage_inst (
        .clk_i             ( clk_i             ),
        .rst_ni            ( rst_ni            ),
        .flush_i           ( flush_i           ),
        .alu_valid_i       ( alu_valid_i       ),
        .branch_valid_i    ( branch_valid_i    ),
        .mult_valid_i      ( mult_valid_i      ),
        .operation_i       ( operation_i       ),
        .operand_a_i       ( operand_a_i       ),
        .operand_b_i       ( operand_b_i       ),
        .imm_i             ( imm_i             ),
        .pc_i              ( pc_i              ),
        .trans_id_i        ( trans_id_i        ),
        .is_compressed_i   ( is_compressed_i   ),
        .predict_taken_i   ( predict_taken_i   ),
        .predict_target_i  ( predict_target_i  ),
        .flu_ready_o       ( flu_ready_o       ),
        .flu_valid_o       ( flu_valid_o       ),
        .flu_result_o      ( flu_result_o      ),
        .flu_trans_id_o    ( flu_trans_id_o    ),
        .resolve_branch_o  ( resolve_branch_o  ),
        .resolved_pc_o     ( resolved_pc_o     ),
        .resolved_target_o ( resolved_target_o ),
        .resolved_taken_o  ( resolved_taken_o  ),
        .mispredict_o      ( mispredict_o      )
    );

    // 20 ns clock
    always #10 clk_i = ~clk_i;

    // Run limit scaled to the table length
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the DUT did not respond within %0d cycles", timeout_limit);
            $display("test failed");
            $finish;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: errors", test_count, name);
        end
    endtask

    task automatic add_entry(input int unit, input ex_pkg::fu_op_e op, input word_t a,
                             input word_t b, input word_t imm, input word_t pc,
                             input logic compressed, input logic pred_taken,
                             input word_t pred_target, input tid_t tid, input word_t res,
                             input logic taken, input word_t target, input logic mis);
        test_entry_t e;
        e = '{unit, op, a, b, imm, pc, compressed, pred_taken, pred_target, tid,
              res, taken, target, mis};
        tests.push_back(e);
    endtask

    // Reference ALU from the operation rules
    function automatic word_t alu_model(input ex_pkg::fu_op_e op, input word_t a, input word_t b);
        int unsigned shamt;
        shamt = b % `EX_XLEN;
        case (op)
            ex_pkg::ADD:  return a + b;
            ex_pkg::SUB:  return a - b;
            ex_pkg::AND:  return a & b;
            ex_pkg::OR:   return a | b;
            ex_pkg::XOR:  return a ^ b;
            ex_pkg::SLL:  return a << shamt;
            ex_pkg::SRL:  return a >> shamt;
            ex_pkg::SRA:  return $signed(a) >>> shamt;
            ex_pkg::SLT:  return word_t'($signed(a) < $signed(b));
            ex_pkg::SLTU: return word_t'(a < b);
            default:      return '0;
        endcase
    endfunction

    task automatic build_tests();
        word_t          a;
        word_t          b;
        ex_pkg::fu_op_e op;
        // Hand worked ALU corner cases
        add_entry(UNIT_ALU, ex_pkg::ADD, 32'd5, 32'd3, '0, '0, 0, 0, '0, 3'd1, 32'd8, 0, '0, 0);
        add_entry(UNIT_ALU, ex_pkg::SUB, 32'd3, 32'd5, '0, '0, 0, 0, '0, 3'd2,
                  32'hffff_fffe, 0, '0, 0);
        add_entry(UNIT_ALU, ex_pkg::SRA, 32'h8000_0000, 32'd4, '0, '0, 0, 0, '0, 3'd3,
                  32'hf800_0000, 0, '0, 0);
        add_entry(UNIT_ALU, ex_pkg::SLT, 32'hffff_ffff, 32'd1, '0, '0, 0, 0, '0, 3'd4,
                  32'd1, 0, '0, 0);
        add_entry(UNIT_ALU, ex_pkg::SLTU, 32'hffff_ffff, 32'd1, '0, '0, 0, 0, '0, 3'd5,
                  32'd0, 0, '0, 0);
        // Random sweep with one row per ALU operation
        for (int k = 0; k < 10; k++) begin
            op = ex_pkg::fu_op_e'(k);
            a  = $random(seed);
            b  = $random(seed);
            add_entry(UNIT_ALU, op, a, b, '0, '0, 0, 0, '0, tid_t'(k), alu_model(op, a, b),
                      0, '0, 0);
        end
        // Branch rows carry the link address as result
        add_entry(UNIT_BRANCH, ex_pkg::EQ, 32'd7, 32'd7, 32'h10, 32'h1000, 0, 1, 32'h1010,
                  3'd6, 32'h1004, 1, 32'h1010, 0);
        add_entry(UNIT_BRANCH, ex_pkg::NE, 32'd7, 32'd7, 32'h20, 32'h2000, 1, 1, 32'h2020,
                  3'd7, 32'h2002, 0, 32'h2020, 1);
        add_entry(UNIT_BRANCH, ex_pkg::LTS, 32'hffff_fff0, 32'd1, 32'hffff_fff8, 32'h3000,
                  0, 1, 32'h3000, 3'd0, 32'h3004, 1, 32'h2ff8, 1);
        add_entry(UNIT_BRANCH, ex_pkg::GEU, 32'd1, 32'hffff_fff0, 32'h40, 32'h4000, 0, 0, '0,
                  3'd1, 32'h4004, 0, 32'h4040, 0);
        add_entry(UNIT_BRANCH, ex_pkg::LTU, 32'd1, 32'd2, 32'h8, 32'h5000, 0, 0, '0,
                  3'd2, 32'h5004, 1, 32'h5008, 1);
        add_entry(UNIT_BRANCH, ex_pkg::GES, 32'hffff_ffff, 32'd0, 32'h4, 32'h6000, 1, 0, '0,
                  3'd3, 32'h6002, 0, 32'h6004, 0);
        add_entry(UNIT_BRANCH, ex_pkg::JALR, 32'h8001, 32'd0, 32'h10, 32'h7000, 0, 1, 32'h8010,
                  3'd4, 32'h7004, 1, 32'h8010, 0);
        add_entry(UNIT_BRANCH, ex_pkg::JALR, 32'h9000, 32'd0, 32'h3, 32'h7100, 1, 1, 32'h9000,
                  3'd5, 32'h7102, 1, 32'h9002, 1);
        // Multiplies issued in back to back pairs
        add_entry(UNIT_MULT, ex_pkg::MUL, 32'h1234, 32'h5678, '0, '0, 0, 0, '0, 3'd6,
                  32'h0626_0060, 0, '0, 0);
        add_entry(UNIT_MULT, ex_pkg::MULH, 32'h8000_0000, 32'd2, '0, '0, 0, 0, '0, 3'd7,
                  32'hffff_ffff, 0, '0, 0);
        add_entry(UNIT_MULT, ex_pkg::MULHU, 32'hffff_ffff, 32'hffff_ffff, '0, '0, 0, 0, '0,
                  3'd0, 32'hffff_fffe, 0, '0, 0);
        add_entry(UNIT_MULT, ex_pkg::MULHSU, 32'hffff_ffff, 32'hffff_ffff, '0, '0, 0, 0, '0,
                  3'd1, 32'hffff_ffff, 0, '0, 0);
    endtask

    // --------------------
    // Issue and checks
    // --------------------
    // Returns at the falling edge of the cycle that accepted the issue
    task automatic issue_entry(input test_entry_t e, input logic flush);
        @(posedge clk_i);
        #1;
        alu_valid_i      = (e.unit == UNIT_ALU);
        branch_valid_i   = (e.unit == UNIT_BRANCH);
        mult_valid_i     = (e.unit == UNIT_MULT);
        operation_i      = e.op;
        operand_a_i      = e.a;
        operand_b_i      = e.b;
        imm_i            = e.imm;
        pc_i             = e.pc;
        trans_id_i       = e.tid;
        is_compressed_i  = e.compressed;
        predict_taken_i  = e.pred_taken;
        predict_target_i = e.pred_target;
        flush_i          = flush;
        @(negedge clk_i);
        while (!flu_ready_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic release_issue();
        @(posedge clk_i);
        #1;
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        mult_valid_i   = 1'b0;
        flush_i        = 1'b0;
    endtask

    // Same cycle result for ALU and branch rows
    task automatic check_single(input test_entry_t e);
        check_value("flu_valid_o", 1, flu_valid_o);
        check_value("flu_result_o", e.exp_result, flu_result_o);
        check_value("flu_trans_id_o", e.tid, flu_trans_id_o);
        check_value("resolve_branch_o", e.unit == UNIT_BRANCH, resolve_branch_o);
        if (e.unit == UNIT_BRANCH) begin
            check_value("resolved_pc_o", e.pc, resolved_pc_o);
            check_value("resolved_target_o", e.exp_target, resolved_target_o);
            check_value("resolved_taken_o", e.exp_taken, resolved_taken_o);
            check_value("mispredict_o", e.exp_mispredict, mispredict_o);
        end
    endtask

    task automatic check_mult(input test_entry_t e);
        check_value("flu_valid_o", 1, flu_valid_o);
        check_value("flu_ready_o", 0, flu_ready_o);
        check_value("flu_result_o", e.exp_result, flu_result_o);
        check_value("flu_trans_id_o", e.tid, flu_trans_id_o);
    endtask

    // Second offer stays up into the first busy cycle and must be refused
    task automatic run_mult_pair(input test_entry_t first, input test_entry_t second);
        int first_cycle;
        issue_entry(first, 1'b0);
        first_cycle = cycle_count;
        issue_entry(second, 1'b0);
        @(negedge clk_i);
        while (!flu_valid_o) begin
            @(negedge clk_i);
        end
        check_value("multiply latency", `EX_MULT_LATENCY, cycle_count - first_cycle);
        check_mult(first);
        release_issue();
        @(negedge clk_i);
        check_mult(second);
    endtask

    // Second multiply rides along with the flush and both must vanish
    task automatic run_flush_test();
        test_entry_t m;
        m = '{UNIT_MULT, ex_pkg::MUL, 32'd3, 32'd5, '0, '0, 0, 0, '0, 3'd2, 32'd15, 0, '0, 0};
        issue_entry(m, 1'b0);
        m.tid = 3'd3;
        issue_entry(m, 1'b1);
        release_issue();
        repeat (`EX_MULT_LATENCY + 1) begin
            @(negedge clk_i);
            check_value("flu_valid_o", 0, flu_valid_o);
            check_value("flu_ready_o", 1, flu_ready_o);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        alu_valid_i      = 1'b0;
        branch_valid_i   = 1'b0;
        mult_valid_i     = 1'b0;
        operation_i      = ex_pkg::ADD;
        operand_a_i      = '0;
        operand_b_i      = '0;
        imm_i            = '0;
        pc_i             = '0;
        trans_id_i       = '0;
        is_compressed_i  = 1'b0;
        predict_taken_i  = 1'b0;
        predict_target_i = '0;
        seed             = 32'h94a3c39d;
        error_count      = 0;
        failed_tests     = 0;
        test_count       = 0;
        cycle_count      = 0;
        build_tests();
        timeout_limit = tests.size() * 8 + 50;

        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // Idle port right after reset
        errors_before = error_count;
        @(negedge clk_i);
        check_value("flu_valid_o", 0, flu_valid_o);
        check_value("resolve_branch_o", 0, resolve_branch_o);
        check_value("flu_ready_o", 1, flu_ready_o);
        report_test("reset state", errors_before);

        idx = 0;
        while (idx < tests.size()) begin
            errors_before = error_count;
            cur_op        = tests[idx].op;
            if (tests[idx].unit == UNIT_MULT) begin
                run_mult_pair(tests[idx], tests[idx + 1]);
                report_test("multiply pair", errors_before);
                idx += 2;
            end else begin
                issue_entry(tests[idx], 1'b0);
                check_single(tests[idx]);
                report_test(cur_op.name(), errors_before);
                idx++;
            end
        end
        release_issue();

        errors_before = error_count;
        run_flush_test();
        report_test("flush in flight", errors_before);

        // Assertion failures from the bound checker
        errors_before = error_count;
        error_count  += int'(ex_stage_inst.ex_stage_asserts_inst.fail_count);
        report_test("bound assertions", errors_before);

        $display("Summary: %0d tests, %0d with errors, %0d failed checks",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- testbench/ex_stage_asserts.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage_asserts (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  logic                            mult_valid_i,
    input  logic                            mult_accept_i,
    input  logic                            branch_valid_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]    trans_id_i,
    input  logic                            resolve_branch_i,
    input  logic                            flu_ready_i,
    input  logic                            flu_valid_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]    flu_trans_id_i
);

    // Failed assertion count for the testbench summary
    int unsigned fail_count = 0;

    // --------------------
    // Issue rules
    // --------------------
    // A multiply offered while the port is busy never reaches the port
    refused_issue_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_valid_i && !flu_ready_i) |-> ##2 flu_ready_i)
        else begin
            $error("Multiply offered to a busy write port produced a result");
            fail_count++;
        end

    // Resolution only for a branch on the issue port
    // Its link goes out on the write port with the issue tag
    resolve_needs_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resolve_branch_i |-> branch_valid_i && flu_valid_i && (flu_trans_id_i == trans_id_i))
        else begin
            $error("Branch resolved without a branch issue and its link write");
            fail_count++;
        end

    // --------------------
    // Multiplier timing
    // --------------------
    // Two cycles issue to result when no flush comes between
    mult_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_accept_i && !flush_i) ##1 !flush_i |=> flu_valid_i)
        else begin
            $error("Multiply result missing two cycles after issue");
            fail_count++;
        end

    // Pipeline empty in reset so the port is free
    ready_in_reset: assert property (@(posedge clk_i)
        !rst_ni |=> flu_ready_i)
        else begin
            $error("Write port not ready during reset");
            fail_count++;
        end

endmodule

bind ex_stage ex_stage_asserts ex_stage_asserts_inst (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .flush_i          ( flush_i          ),
    .mult_valid_i     ( mult_valid_i     ),
    .mult_accept_i    ( mult_accept      ),
    .branch_valid_i   ( branch_valid_i   ),
    .trans_id_i       ( trans_id_i       ),
    .resolve_branch_i ( resolve_branch_o ),
    .flu_ready_i      ( flu_ready_o      ),
    .flu_valid_i      ( flu_valid_o      ),
    .flu_trans_id_i   ( flu_trans_id_o   )
);

//--- hdl/ex_stage.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    // Issue port
    input  logic                            alu_valid_i,
    input  logic                            branch_valid_i,
    input  logic                            mult_valid_i,
    input  ex_pkg::fu_op_e                  operation_i,
    input  logic [`EX_XLEN-1:0]             operand_a_i,
    input  logic [`EX_XLEN-1:0]             operand_b_i,
    input  logic [`EX_XLEN-1:0]             imm_i,
    input  logic [`EX_XLEN-1:0]             pc_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]    trans_id_i,
    input  logic                            is_compressed_i,
    // Branch prediction from the front end
    input  logic                            predict_taken_i,
    input  logic [`EX_XLEN-1:0]             predict_target_i,
    // Scoreboard write port
    output logic                            flu_ready_o,
    output logic                            flu_valid_o,
    output logic [`EX_XLEN-1:0]             flu_result_o,
    output logic [`EX_TRANS_ID_BITS-1:0]    flu_trans_id_o,
    // Branch resolution
    output logic                            resolve_branch_o,
    output logic [`EX_XLEN-1:0]             resolved_pc_o,
    output logic [`EX_XLEN-1:0]             resolved_target_o,
    output logic                            resolved_taken_o,
    output logic                            mispredict_o
);

    // --------------------
    // Issue acceptance
    // --------------------
    // Only place where ready meets the issue valids
    logic alu_accept;
    logic branch_accept;
    logic mult_accept;
    // ALU operands also feed the branch unit
    logic alu_sel;

    assign alu_accept    = alu_valid_i & flu_ready_o;
    assign branch_accept = branch_valid_i & flu_ready_o;
    assign mult_accept   = mult_valid_i & flu_ready_o;
    assign alu_sel       = alu_accept | branch_accept;

    // Unit results and side paths
    ex_pkg::fu_result_t     alu_result;
    ex_pkg::fu_result_t     mult_result;
    logic                   alu_compare;
    logic [`EX_XLEN-1:0]    branch_link;

    fu_issue_if alu_issue ();
    fu_issue_if mult_issue ();

    // --------------------
    // Operand silencing
    // --------------------
    // Idle units see zeros to keep their logic quiet
    assign alu_issue.valid     = alu_accept;
    assign alu_issue.operation = alu_sel ? operation_i : ex_pkg::ADD;
    assign alu_issue.operand_a = alu_sel ? operand_a_i : '0;
    assign alu_issue.operand_b = alu_sel ? operand_b_i : '0;
    assign alu_issue.imm       = alu_sel ? imm_i : '0;
    assign alu_issue.trans_id  = alu_sel ? trans_id_i : '0;

    assign mult_issue.valid     = mult_accept;
    assign mult_issue.operation = mult_accept ? operation_i : ex_pkg::ADD;
    assign mult_issue.operand_a = mult_accept ? operand_a_i : '0;
    assign mult_issue.operand_b = mult_accept ? operand_b_i : '0;
    assign mult_issue.imm       = mult_accept ? imm_i : '0;
    assign mult_issue.trans_id  = mult_accept ? trans_id_i : '0;

    // --------------------
    // Functional units
    // --------------------
    // Single cycle, combinational
    alu alu_inst (
        .clk_i     ( clk_i       ),
        .rst_ni    ( rst_ni      ),
        .issue     ( alu_issue   ),
        .result_o  ( alu_result  ),
        .compare_o ( alu_compare )
    );

    // Resolves beside the ALU using its compare
    branch_unit branch_unit_inst (
        .issue             ( alu_issue         ),
        .branch_valid_i    ( branch_accept     ),
        .pc_i              ( pc_i              ),
        .is_compressed_i   ( is_compressed_i   ),
        .predict_taken_i   ( predict_taken_i   ),
        .predict_target_i  ( predict_target_i  ),
        .compare_i         ( alu_compare       ),
        .link_o            ( branch_link       ),
        .resolve_branch_o  ( resolve_branch_o  ),
        .resolved_pc_o     ( resolved_pc_o     ),
        .resolved_target_o ( resolved_target_o ),
        .resolved_taken_o  ( resolved_taken_o  ),
        .mispredict_o      ( mispredict_o      )
    );

    // Two stage pipeline
    mult mult_inst (
        .clk_i    ( clk_i       ),
        .rst_ni   ( rst_ni      ),
        .flush_i  ( flush_i     ),
        .issue    ( mult_issue  ),
        .result_o ( mult_result )
    );

    // Shared write port and ready
    flu_writeback flu_writeback_inst (
        .alu_result_i   ( alu_result         ),
        .mult_result_i  ( mult_result        ),
        .branch_valid_i ( branch_accept      ),
        .link_i         ( branch_link        ),
        .trans_id_i     ( alu_issue.trans_id ),
        .flu_ready_o    ( flu_ready_o        ),
        .flu_valid_o    ( flu_valid_o        ),
        .flu_result_o   ( flu_result_o       ),
        .flu_trans_id_o ( flu_trans_id_o     )
    );

endmodule

//--- mult/mult.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module mult (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    fu_issue_if.unit            issue,
    output ex_pkg::fu_result_t  result_o
);

    // Stage 1 operands
    logic                           s1_valid;
    ex_pkg::fu_op_e                 s1_op;
    logic [`EX_XLEN-1:0]            s1_a;
    logic [`EX_XLEN-1:0]            s1_b;
    logic [`EX_TRANS_ID_BITS-1:0]   s1_trans_id;
    // Stage 2 result
    logic                           s2_valid;
    logic [`EX_XLEN-1:0]            s2_result;
    logic [`EX_TRANS_ID_BITS-1:0]   s2_trans_id;

    // Sign extended by one bit so the product is two bits wider
    logic                           a_signed;
    logic                           b_signed;
    logic [`EX_XLEN:0]              a_ext;
    logic [`EX_XLEN:0]              b_ext;
    logic [2*`EX_XLEN+1:0]          product;
    logic [`EX_XLEN-1:0]            slice;

    // --------------------
    // Valid pipeline
    // --------------------
    // Flush drops everything in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid & ~flush_i;
            s2_valid <= s1_valid & ~flush_i;
        end
    end

    // Stage 1 capture
    always_ff @(posedge clk_i) begin
        s1_op       <= issue.operation;
        s1_a        <= issue.operand_a;
        s1_b        <= issue.operand_b;
        s1_trans_id <= issue.trans_id;
    end

    // --------------------
    // Product
    // --------------------
    // MULHSU signs only a and MULH both
    assign a_signed = (s1_op == ex_pkg::MULH) | (s1_op == ex_pkg::MULHSU);
    assign b_signed = (s1_op == ex_pkg::MULH);
    assign a_ext    = {a_signed & s1_a[`EX_XLEN-1], s1_a};
    assign b_ext    = {b_signed & s1_b[`EX_XLEN-1], s1_b};
    // Full width signed product
    assign product  = $signed(a_ext) * $signed(b_ext);

    // Low word for MUL and high word otherwise
    assign slice = (s1_op == ex_pkg::MUL) ? product[`EX_XLEN-1:0]
                                          : product[2*`EX_XLEN-1:`EX_XLEN];

    // Stage 2 capture
    always_ff @(posedge clk_i) begin
        s2_result   <= slice;
        s2_trans_id <= s1_trans_id;
    end

    assign result_o = '{
        valid:    s2_valid,
        result:   s2_result,
        trans_id: s2_trans_id
    };

endmodule

//--- hdl/flu_writeback.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module flu_writeback (
    input  ex_pkg::fu_result_t              alu_result_i,
    input  ex_pkg::fu_result_t              mult_result_i,
    input  logic                            branch_valid_i,
    input  logic [`EX_XLEN-1:0]             link_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]    trans_id_i,
    output logic                            flu_ready_o,
    output logic                            flu_valid_o,
    output logic [`EX_XLEN-1:0]             flu_result_o,
    output logic [`EX_TRANS_ID_BITS-1:0]    flu_trans_id_o
);

    // Port busy with a multiply result blocks issue
    // Mult valid is registered so ready is too
    assign flu_ready_o = ~mult_result_i.valid;

    assign flu_valid_o = mult_result_i.valid | alu_result_i.valid | branch_valid_i;

    // --------------------
    // Result mux
    // --------------------
    always_comb begin
        // Branch link by default
        flu_result_o   = link_i;
        flu_trans_id_o = trans_id_i;
        if (mult_result_i.valid) begin
            // Multiply keeps its own slot ID
            flu_result_o   = mult_result_i.result;
            flu_trans_id_o = mult_result_i.trans_id;
        end else if (alu_result_i.valid) begin
            flu_result_o   = alu_result_i.result;
            flu_trans_id_o = alu_result_i.trans_id;
        end
    end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module branch_unit (
    fu_issue_if.unit                    issue,
    input  logic                        branch_valid_i,
    input  logic [`EX_XLEN-1:0]         pc_i,
    input  logic                        is_compressed_i,
    input  logic                        predict_taken_i,
    input  logic [`EX_XLEN-1:0]         predict_target_i,
    // Branch condition from the ALU
    input  logic                        compare_i,
    // Return address for the write port
    output logic [`EX_XLEN-1:0]         link_o,
    output logic                        resolve_branch_o,
    output logic [`EX_XLEN-1:0]         resolved_pc_o,
    output logic [`EX_XLEN-1:0]         resolved_target_o,
    output logic                        resolved_taken_o,
    output logic                        mispredict_o
);

    logic                   is_jalr;
    logic [`EX_XLEN-1:0]    target_base;
    logic [`EX_XLEN-1:0]    target_sum;
    logic [`EX_XLEN-1:0]    target;
    logic                   taken;
    logic                   wrong_dir;
    logic                   wrong_target;

    // --------------------
    // Target calculation
    // --------------------
    assign is_jalr     = (issue.operation == ex_pkg::JALR);
    // Register based for JALR, PC relative otherwise
    assign target_base = is_jalr ? issue.operand_a : pc_i;
    assign target_sum  = target_base + issue.imm;
    // Jump target always halfword aligned
    assign target      = is_jalr ? {target_sum[`EX_XLEN-1:1], 1'b0} : target_sum;

    // Next sequential PC, compressed is two bytes
    assign link_o = pc_i + (is_compressed_i ? `EX_XLEN'd2 : `EX_XLEN'd4);

    // --------------------
    // Resolution
    // --------------------
    // JALR unconditional
    assign taken = is_jalr | compare_i;

    // Direction wrong
    assign wrong_dir    = (taken != predict_taken_i);
    // Taken but predicted elsewhere
    assign wrong_target = taken & (target != predict_target_i);

    assign resolve_branch_o  = branch_valid_i;
    assign resolved_pc_o     = pc_i;
    assign resolved_target_o = target;
    assign resolved_taken_o  = branch_valid_i & taken;
    assign mispredict_o      = branch_valid_i & (wrong_dir | wrong_target);

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module alu (
    input  logic                clk_i,
    input  logic                rst_ni,
    fu_issue_if.unit            issue,
    output ex_pkg::fu_result_t  result_o,
    output logic                compare_o
);

    localparam int unsigned SHAMT_BITS = $clog2(`EX_XLEN);

    logic [SHAMT_BITS-1:0]  shamt;
    // Subtraction with borrow out
    logic [`EX_XLEN:0]      sub_ext;
    logic                   eq;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [`EX_XLEN-1:0]    alu_out;

    // --------------------
    // Shared comparator
    // --------------------
    assign shamt       = issue.operand_b[SHAMT_BITS-1:0];
    assign sub_ext     = {1'b0, issue.operand_a} - {1'b0, issue.operand_b};
    assign eq          = (issue.operand_a == issue.operand_b);
    // Borrow means a below b
    assign lt_unsigned = sub_ext[`EX_XLEN];
    assign lt_signed   = ($signed(issue.operand_a) < $signed(issue.operand_b));

    // Branch condition for the branch unit
    always_comb begin
        case (issue.operation)
            ex_pkg::EQ:  compare_o = eq;
            ex_pkg::NE:  compare_o = ~eq;
            ex_pkg::LTS: compare_o = lt_signed;
            ex_pkg::GES: compare_o = ~lt_signed;
            ex_pkg::LTU: compare_o = lt_unsigned;
            ex_pkg::GEU: compare_o = ~lt_unsigned;
            default:     compare_o = 1'b0;
        endcase
    end

    // --------------------
    // Result select
    // --------------------
    always_comb begin
        case (issue.operation)
            ex_pkg::ADD:  alu_out = issue.operand_a + issue.operand_b;
            ex_pkg::SUB:  alu_out = sub_ext[`EX_XLEN-1:0];
            ex_pkg::AND:  alu_out = issue.operand_a & issue.operand_b;
            ex_pkg::OR:   alu_out = issue.operand_a | issue.operand_b;
            ex_pkg::XOR:  alu_out = issue.operand_a ^ issue.operand_b;
            ex_pkg::SLL:  alu_out = issue.operand_a << shamt;
            ex_pkg::SRL:  alu_out = issue.operand_a >> shamt;
            // Arithmetic shift keeps the sign
            ex_pkg::SRA:  alu_out = $unsigned($signed(issue.operand_a) >>> shamt);
            ex_pkg::SLT:  alu_out = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            ex_pkg::SLTU: alu_out = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            // Branches and jumps write nothing from here
            default:      alu_out = '0;
        endcase
    end

    // Valid follows issue, result in the same cycle
    assign result_o = '{
        valid:    issue.valid,
        result:   alu_out,
        trans_id: issue.trans_id
    };

endmodule

//--- common/fu_issue_if.sv
`timescale 1ns/1ps
`include "ex_config.svh"

// One issue slot from the stage into a functional unit
interface fu_issue_if;

    // Accepted issue, already gated with ready
    logic                           valid;
    // Silenced to zero when the unit is idle
    ex_pkg::fu_op_e                 operation;
    logic [`EX_XLEN-1:0]            operand_a;
    logic [`EX_XLEN-1:0]            operand_b;
    logic [`EX_XLEN-1:0]            imm;
    logic [`EX_TRANS_ID_BITS-1:0]   trans_id;

    // Stage side
    modport issuer (
        output valid, operation,
        output operand_a, operand_b, imm,
        output trans_id
    );

    // Functional unit side
    modport unit (
        input valid, operation,
        input operand_a, operand_b, imm,
        input trans_id
    );

endinterface

//--- common/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

    // --------------------
    // Operation codes
    // --------------------
    typedef enum logic [4:0] {
        // Arithmetic and logic
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set less than
        SLT,
        SLTU,
        // Conditional branches, ALU comparison only
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        // Indirect jump, always taken
        JALR,
        // Multiplier, low word
        MUL,
        // Multiplier, high word variants
        MULH,
        MULHU,
        MULHSU
    } fu_op_e;

    // --------------------
    // Unit result
    // --------------------
    // One write-back candidate from a functional unit
    typedef struct packed {
        // Result present this cycle
        logic                           valid;
        // Value for the register file
        logic [`EX_XLEN-1:0]            result;
        // Scoreboard slot to write
        logic [`EX_TRANS_ID_BITS-1:0]   trans_id;
    } fu_result_t;

    // Idle result for units with nothing to report
    localparam fu_result_t FU_RESULT_IDLE = '{
        valid:    1'b0,
        result:   '0,
        trans_id: '0
    };

    // Branch operations take their outcome from the ALU compare
    function automatic logic is_branch_op(fu_op_e op);
        return (op inside {EQ, NE, LTS, GES, LTU, GEU});
    endfunction

endpackage

//--- common/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path width
`define EX_XLEN 32

// Scoreboard entry ID width
`define EX_TRANS_ID_BITS 3

// Multiplier latency in cycles, issue to result
`define EX_MULT_LATENCY 2

`endif
